// ==== rtl/x86_decode_pkg.sv ====
`default_nettype none

package x86_decode_pkg;

  // Operand or register value
  typedef logic [31:0] word_t;

  // Register number in ModR/M encoding order
  typedef logic [2:0] reg_sel_t;

  // Operand encoding form of the primary opcode
  typedef logic [3:0] opnd_form_t;

  // Decoded command
  typedef logic [5:0] cmd_t;

  // Where an operand result goes
  typedef logic [1:0] dest_kind_t;

  // Nine-byte fetch window, opcode in bits 7:0
  typedef logic [71:0] instr_win_t;

  // Length in bytes, at most 11 for this subset
  typedef logic [3:0] instr_len_t;

  // Operand forms
  localparam opnd_form_t FORM_NONE       = 4'd0;
  localparam opnd_form_t FORM_REG        = 4'd1;
  localparam opnd_form_t FORM_REG_IMM    = 4'd2;
  localparam opnd_form_t FORM_EAX_IMM    = 4'd3;
  localparam opnd_form_t FORM_EAX_REG    = 4'd4;
  localparam opnd_form_t FORM_RM         = 4'd5;
  localparam opnd_form_t FORM_RM_IMM     = 4'd6;
  localparam opnd_form_t FORM_RM_REG     = 4'd7;
  localparam opnd_form_t FORM_REG_RM     = 4'd8;
  localparam opnd_form_t FORM_REG_RM_IMM = 4'd9;

  // Commands
  localparam cmd_t CMD_NONE = 6'd0;
  localparam cmd_t CMD_ADD  = 6'd1;
  localparam cmd_t CMD_OR   = 6'd2;
  localparam cmd_t CMD_AND  = 6'd3;
  localparam cmd_t CMD_SUB  = 6'd4;
  localparam cmd_t CMD_XOR  = 6'd5;
  localparam cmd_t CMD_CMP  = 6'd6;
  localparam cmd_t CMD_MOV  = 6'd7;
  localparam cmd_t CMD_INC  = 6'd8;
  localparam cmd_t CMD_DEC  = 6'd9;
  localparam cmd_t CMD_XCHG = 6'd10;
  localparam cmd_t CMD_IMUL = 6'd11;
  localparam cmd_t CMD_MOVS = 6'd12;
  localparam cmd_t CMD_CMPS = 6'd13;
  localparam cmd_t CMD_STOS = 6'd14;
  localparam cmd_t CMD_LODS = 6'd15;
  localparam cmd_t CMD_SCAS = 6'd16;

  // Destination kinds
  localparam dest_kind_t DEST_NONE = 2'd0;
  localparam dest_kind_t DEST_REG  = 2'd1;
  localparam dest_kind_t DEST_MEM  = 2'd2;

  // General registers
  localparam reg_sel_t REG_EAX = 3'd0;
  localparam reg_sel_t REG_ECX = 3'd1;
  localparam reg_sel_t REG_EDX = 3'd2;
  localparam reg_sel_t REG_EBX = 3'd3;
  localparam reg_sel_t REG_ESP = 3'd4;
  localparam reg_sel_t REG_EBP = 3'd5;
  localparam reg_sel_t REG_ESI = 3'd6;
  localparam reg_sel_t REG_EDI = 3'd7;

endpackage

`default_nettype wire

// ==== rtl/gpr_file.sv ====
`default_nettype none

module gpr_file
  import x86_decode_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     wr_en,
  input  reg_sel_t wr_sel,
  input  word_t    wr_data,
  output word_t    eax,
  output word_t    ecx,
  output word_t    edx,
  output word_t    ebx,
  output word_t    esp,
  output word_t    ebp,
  output word_t    esi,
  output word_t    edi
);

  // Architectural state, indexed by register number
  word_t regs [8];
  // Read view including a same-cycle write
  word_t rd [8];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 8; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[wr_sel] <= wr_data;
    end
  end

  // Write-through bypass so the decoder sees the new value this cycle
  always_comb begin
    for (int i = 0; i < 8; i++) begin
      rd[i] = (wr_en && wr_sel == reg_sel_t'(i)) ? wr_data : regs[i];
    end
  end

  assign eax = rd[REG_EAX];
  assign ecx = rd[REG_ECX];
  assign edx = rd[REG_EDX];
  assign ebx = rd[REG_EBX];
  assign esp = rd[REG_ESP];
  assign ebp = rd[REG_EBP];
  assign esi = rd[REG_ESI];
  assign edi = rd[REG_EDI];

endmodule

`default_nettype wire

// ==== rtl/opcode_classify.sv ====
`default_nettype none

module opcode_classify
  import x86_decode_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       instr_valid,
  input  instr_win_t instr,
  input  logic       prefix_operand_16bit,
  input  logic       prefix_address_16bit,
  output logic       stage_valid,
  output instr_win_t stage_instr,
  output logic       stage_prefix_operand_16bit,
  output logic       stage_prefix_address_16bit,
  output cmd_t       cmd,
  output opnd_form_t opnd_form,
  output logic       imm_1byte,
  output logic       reg_1byte
);

  // ALU operation field, shared by opcode bits 5:3 and the group-1 reg field
  // ADC and SBB fall outside the subset
  function automatic cmd_t alu_op(logic [2:0] op_field);
    cmd_t result;
    case (op_field)
      3'd0:    result = CMD_ADD;
      3'd1:    result = CMD_OR;
      3'd4:    result = CMD_AND;
      3'd5:    result = CMD_SUB;
      3'd6:    result = CMD_XOR;
      3'd7:    result = CMD_CMP;
      default: result = CMD_NONE;
    endcase
    return result;
  endfunction

  logic [7:0] opcode;
  logic [2:0] modrm_reg;
  cmd_t       d_cmd;
  opnd_form_t d_form;
  logic       d_imm_1byte;
  logic       d_reg_1byte;

  assign opcode    = instr[7:0];
  assign modrm_reg = instr[13:11];

  always_comb begin
    d_cmd       = CMD_NONE;
    d_form      = FORM_NONE;
    d_imm_1byte = 1'b0;
    d_reg_1byte = 1'b0;
    if (opcode[7:6] == 2'b00 && opcode[2:0] <= 3'd5) begin
      // 00..3D ALU block, bit 0 clear is byte size
      d_cmd       = alu_op(opcode[5:3]);
      d_reg_1byte = ~opcode[0];
      case (opcode[2:1])
        2'b00:   d_form = FORM_RM_REG;
        2'b01:   d_form = FORM_REG_RM;
        default: begin
          d_form      = FORM_EAX_IMM;
          d_imm_1byte = ~opcode[0];
        end
      endcase
    end else begin
      casez (opcode)
        8'b0100_0???: begin
          d_cmd  = CMD_INC;
          d_form = FORM_REG;
        end
        8'b0100_1???: begin
          d_cmd  = CMD_DEC;
          d_form = FORM_REG;
        end
        8'h69, 8'h6B: begin
          d_cmd       = CMD_IMUL;
          d_form      = FORM_REG_RM_IMM;
          d_imm_1byte = opcode[1];
        end
        8'h80, 8'h81, 8'h83: begin
          // Group 1 takes the operation from ModR/M
          d_cmd       = alu_op(modrm_reg);
          d_form      = FORM_RM_IMM;
          d_reg_1byte = ~opcode[0];
          d_imm_1byte = opcode[1] | ~opcode[0];
        end
        8'b1000_10??: begin
          d_cmd       = CMD_MOV;
          d_form      = opcode[1] ? FORM_REG_RM : FORM_RM_REG;
          d_reg_1byte = ~opcode[0];
        end
        8'b1001_0???: begin
          d_cmd  = CMD_XCHG;
          d_form = FORM_EAX_REG;
        end
        8'b1011_1???: begin
          d_cmd  = CMD_MOV;
          d_form = FORM_REG_IMM;
        end
        // String ops carry no explicit operands
        8'hA4, 8'hA5: d_cmd = CMD_MOVS;
        8'hA6, 8'hA7: d_cmd = CMD_CMPS;
        8'hAA, 8'hAB: d_cmd = CMD_STOS;
        8'hAC, 8'hAD: d_cmd = CMD_LODS;
        8'hAE, 8'hAF: d_cmd = CMD_SCAS;
        default: d_cmd = CMD_NONE;
      endcase
      if (opcode[7:4] == 4'hA) begin
        d_reg_1byte = ~opcode[0];
      end
    end
    // Anything unrecognised, including ADC/SBB, decodes to nothing
    if (d_cmd == CMD_NONE) begin
      d_form      = FORM_NONE;
      d_imm_1byte = 1'b0;
      d_reg_1byte = 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      stage_valid <= 1'b0;
      cmd         <= CMD_NONE;
      opnd_form   <= FORM_NONE;
      imm_1byte   <= 1'b0;
      reg_1byte   <= 1'b0;
    end else begin
      stage_valid <= instr_valid;
      if (instr_valid) begin
        cmd       <= d_cmd;
        opnd_form <= d_form;
        imm_1byte <= d_imm_1byte;
        reg_1byte <= d_reg_1byte;
      end
    end
  end

  // Window and prefixes only load with a new instruction
  always_ff @(posedge clk) begin
    if (instr_valid) begin
      stage_instr                <= instr;
      stage_prefix_operand_16bit <= prefix_operand_16bit;
      stage_prefix_address_16bit <= prefix_address_16bit;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/decode_opnds.sv ====
`default_nettype none

module decode_opnds
  import x86_decode_pkg::*;
(
  input  logic       stage_valid,
  input  instr_win_t stage_instr,
  input  logic       stage_prefix_operand_16bit,
  input  logic       stage_prefix_address_16bit,
  input  cmd_t       cmd,
  input  opnd_form_t opnd_form,
  input  logic       imm_1byte,
  input  logic       reg_1byte,
  input  word_t      eax,
  input  word_t      ecx,
  input  word_t      edx,
  input  word_t      ebx,
  input  word_t      esp,
  input  word_t      ebp,
  input  word_t      esi,
  input  word_t      edi,
  output logic       out_valid,
  output word_t      opnd0,
  output word_t      opnd1,
  output word_t      opnd2,
  output word_t      disp,
  output logic       disp_1byte,
  output logic       has_sib,
  output instr_len_t instr_len,
  output dest_kind_t dest0_kind,
  output dest_kind_t dest1_kind,
  output reg_sel_t   dest0_sel,
  output reg_sel_t   dest1_sel
);

  // Four bytes of the window starting at byte pos, zero past the end
  function automatic word_t bytes_at(instr_win_t win, logic [3:0] pos);
    instr_win_t shifted;
    shifted = win >> {pos, 3'b000};
    return shifted[31:0];
  endfunction

  // Register read with AL..BL / AH..BH narrowing
  function automatic word_t read_gpr(word_t [7:0] bank, reg_sel_t sel, logic narrow);
    word_t low_reg;
    word_t value;
    low_reg = bank[{1'b0, sel[1:0]}];
    if (!narrow) begin
      value = bank[sel];
    end else if (sel[2]) begin
      value = {24'd0, low_reg[15:8]};
    end else begin
      value = {24'd0, low_reg[7:0]};
    end
    return value;
  endfunction

  word_t [7:0] gpr_bank;
  logic [7:0]  modrm;
  logic        mod_direct;
  logic        rm_first;
  logic        reg_first;
  logic        has_modrm;
  logic        has_imm;
  logic [3:0]  disp_len;
  logic [3:0]  imm_len;
  logic [3:0]  disp_pos;
  logic [3:0]  imm_pos;
  word_t       disp_raw;
  word_t       imm_raw;
  reg_sel_t    sel0;
  reg_sel_t    sel1;
  logic        opnd0_is_reg;
  logic        opnd1_is_reg;
  logic        opnd0_mem;
  logic        mov_load;

  assign gpr_bank = {edi, esi, ebp, esp, ebx, edx, ecx, eax};

  // Form classification
  assign rm_first  = opnd_form == FORM_RM || opnd_form == FORM_RM_IMM ||
                     opnd_form == FORM_RM_REG;
  assign reg_first = opnd_form == FORM_REG_RM || opnd_form == FORM_REG_RM_IMM;
  assign has_modrm = rm_first || reg_first;
  assign has_imm   = opnd_form == FORM_REG_IMM || opnd_form == FORM_EAX_IMM ||
                     opnd_form == FORM_RM_IMM || opnd_form == FORM_REG_RM_IMM;

  assign modrm      = stage_instr[15:8];
  assign mod_direct = modrm[7:6] == 2'b11;

  // SIB only exists with 32-bit addressing
  assign has_sib = has_modrm && !stage_prefix_address_16bit && !mod_direct &&
                   modrm[2:0] == 3'b100;

  always_comb begin
    disp_len = 4'd0;
    if (has_modrm && !mod_direct) begin
      case (modrm[7:6])
        2'b01:   disp_len = 4'd1;
        2'b10:   disp_len = stage_prefix_address_16bit ? 4'd2 : 4'd4;
        default: begin
          // mod 00 direct-address encodings
          if (!stage_prefix_address_16bit && modrm[2:0] == 3'b101) begin
            disp_len = 4'd4;
          end else if (stage_prefix_address_16bit && modrm[2:0] == 3'b110) begin
            disp_len = 4'd2;
          end
        end
      endcase
    end
  end

  assign imm_len = !has_imm ? 4'd0 :
                   imm_1byte ? 4'd1 :
                   stage_prefix_operand_16bit ? 4'd2 : 4'd4;

  // Byte positions follow opcode, ModR/M, SIB, displacement
  assign disp_pos  = 4'd1 + {3'd0, has_modrm} + {3'd0, has_sib};
  assign imm_pos   = disp_pos + disp_len;
  assign instr_len = imm_pos + imm_len;

  assign disp_raw = bytes_at(stage_instr, disp_pos);
  assign imm_raw  = bytes_at(stage_instr, imm_pos);

  always_comb begin
    case (disp_len)
      4'd1:    disp = {{24{disp_raw[7]}}, disp_raw[7:0]};
      4'd2:    disp = {{16{disp_raw[15]}}, disp_raw[15:0]};
      4'd4:    disp = disp_raw;
      default: disp = '0;
    endcase
    // 16-bit immediates are zero-extended
    case (imm_len)
      4'd1:    opnd2 = {{24{imm_raw[7]}}, imm_raw[7:0]};
      4'd2:    opnd2 = {16'd0, imm_raw[15:0]};
      4'd4:    opnd2 = imm_raw;
      default: opnd2 = '0;
    endcase
  end

  assign disp_1byte = disp_len == 4'd1;

  // Operand 0 selector sources
  assign sel0 = (opnd_form == FORM_REG || opnd_form == FORM_REG_IMM) ? stage_instr[2:0] :
                (rm_first && mod_direct) ? modrm[2:0] :
                reg_first ? modrm[5:3] : REG_EAX;
  assign opnd0_is_reg = opnd_form == FORM_REG || opnd_form == FORM_REG_IMM ||
                        opnd_form == FORM_EAX_IMM || opnd_form == FORM_EAX_REG ||
                        (rm_first && mod_direct) || reg_first;

  // Operand 1 selector sources
  assign sel1 = (opnd_form == FORM_RM_REG) ? modrm[5:3] :
                (reg_first && mod_direct) ? modrm[2:0] :
                (opnd_form == FORM_EAX_REG) ? stage_instr[2:0] : REG_EAX;
  assign opnd1_is_reg = opnd_form == FORM_RM_REG || opnd_form == FORM_EAX_REG ||
                        (reg_first && mod_direct);

  assign opnd0 = opnd0_is_reg ? read_gpr(gpr_bank, sel0, reg_1byte) : '0;
  assign opnd1 = opnd1_is_reg ? read_gpr(gpr_bank, sel1, reg_1byte) : '0;

  assign opnd0_mem = (rm_first && !mod_direct) || cmd == CMD_MOVS || cmd == CMD_CMPS ||
                     cmd == CMD_SCAS || cmd == CMD_LODS;

  // Compares write nothing back
  assign dest0_kind = (cmd == CMD_CMP || cmd == CMD_CMPS) ? DEST_NONE :
                      opnd0_mem ? DEST_MEM :
                      opnd0_is_reg ? DEST_REG : DEST_NONE;

  // MOV 8A/8B loads into its reg-first operand
  assign mov_load   = cmd == CMD_MOV && opnd_form == FORM_REG_RM;
  assign dest1_kind = (cmd == CMD_XCHG || mov_load) ? DEST_REG : DEST_NONE;

  assign dest0_sel = (dest0_kind == DEST_REG) ? sel0 : '0;
  assign dest1_sel = (dest1_kind != DEST_REG) ? '0 : mov_load ? sel0 : sel1;

  assign out_valid = stage_valid;

endmodule

`default_nettype wire

// ==== rtl/x86_decode_top.sv ====
`default_nettype none

module x86_decode_top
  import x86_decode_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       instr_valid,
  input  instr_win_t instr,
  input  logic       prefix_operand_16bit,
  input  logic       prefix_address_16bit,
  input  logic       wr_en,
  input  reg_sel_t   wr_sel,
  input  word_t      wr_data,
  output logic       out_valid,
  output word_t      opnd0,
  output word_t      opnd1,
  output word_t      opnd2,
  output word_t      disp,
  output logic       disp_1byte,
  output logic       has_sib,
  output instr_len_t instr_len,
  output dest_kind_t dest0_kind,
  output dest_kind_t dest1_kind,
  output reg_sel_t   dest0_sel,
  output reg_sel_t   dest1_sel
);

  // Stage 1 to stage 2
  logic       stage_valid;
  instr_win_t stage_instr;
  logic       stage_prefix_operand_16bit;
  logic       stage_prefix_address_16bit;
  cmd_t       cmd;
  opnd_form_t opnd_form;
  logic       imm_1byte;
  logic       reg_1byte;

  // Register file read outputs
  word_t eax;
  word_t ecx;
  word_t edx;
  word_t ebx;
  word_t esp;
  word_t ebp;
  word_t esi;
  word_t edi;

  opcode_classify i_classify (
    .clk                        (clk),
    .rst                        (rst),
    .instr_valid                (instr_valid),
    .instr                      (instr),
    .prefix_operand_16bit       (prefix_operand_16bit),
    .prefix_address_16bit       (prefix_address_16bit),
    .stage_valid                (stage_valid),
    .stage_instr                (stage_instr),
    .stage_prefix_operand_16bit (stage_prefix_operand_16bit),
    .stage_prefix_address_16bit (stage_prefix_address_16bit),
    .cmd                        (cmd),
    .opnd_form                  (opnd_form),
    .imm_1byte                  (imm_1byte),
    .reg_1byte                  (reg_1byte)
  );

  gpr_file i_gpr (
    .clk     (clk),
    .rst     (rst),
    .wr_en   (wr_en),
    .wr_sel  (wr_sel),
    .wr_data (wr_data),
    .eax     (eax),
    .ecx     (ecx),
    .edx     (edx),
    .ebx     (ebx),
    .esp     (esp),
    .ebp     (ebp),
    .esi     (esi),
    .edi     (edi)
  );

  decode_opnds i_decode (
    .stage_valid                (stage_valid),
    .stage_instr                (stage_instr),
    .stage_prefix_operand_16bit (stage_prefix_operand_16bit),
    .stage_prefix_address_16bit (stage_prefix_address_16bit),
    .cmd                        (cmd),
    .opnd_form                  (opnd_form),
    .imm_1byte                  (imm_1byte),
    .reg_1byte                  (reg_1byte),
    .eax                        (eax),
    .ecx                        (ecx),
    .edx                        (edx),
    .ebx                        (ebx),
    .esp                        (esp),
    .ebp                        (ebp),
    .esi                        (esi),
    .edi                        (edi),
    .out_valid                  (out_valid),
    .opnd0                      (opnd0),
    .opnd1                      (opnd1),
    .opnd2                      (opnd2),
    .disp                       (disp),
    .disp_1byte                 (disp_1byte),
    .has_sib                    (has_sib),
    .instr_len                  (instr_len),
    .dest0_kind                 (dest0_kind),
    .dest1_kind                 (dest1_kind),
    .dest0_sel                  (dest0_sel),
    .dest1_sel                  (dest1_sel)
  );

endmodule

`default_nettype wire

// ==== sim/tb_x86_decode.sv ====
`default_nettype none

module tb_x86_decode
  import x86_decode_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  // About 80 cycles of stimulus, so this only trips on a hang
  localparam int          CYCLE_LIMIT = 2000;
  localparam logic [31:0] LFSR_SEED   = 32'h887a;
  // Galois taps for x^32 + x^22 + x^2 + x + 1
  localparam logic [31:0] LFSR_TAPS   = 32'h80200003;

  logic       clk;
  logic       rst;
  logic       instr_valid;
  instr_win_t instr;
  logic       prefix_operand_16bit;
  logic       prefix_address_16bit;
  logic       wr_en;
  reg_sel_t   wr_sel;
  word_t      wr_data;
  logic       out_valid;
  word_t      opnd0;
  word_t      opnd1;
  word_t      opnd2;
  word_t      disp;
  logic       disp_1byte;
  logic       has_sib;
  instr_len_t instr_len;
  dest_kind_t dest0_kind;
  dest_kind_t dest1_kind;
  reg_sel_t   dest0_sel;
  reg_sel_t   dest1_sel;

  // Expected result for the current out_valid cycle
  logic       exp_valid;
  word_t      exp_opnd0;
  word_t      exp_opnd1;
  word_t      exp_opnd2;
  word_t      exp_disp;
  logic       exp_disp_1byte;
  logic       exp_has_sib;
  instr_len_t exp_len;
  dest_kind_t exp_dest0_kind;
  dest_kind_t exp_dest1_kind;
  reg_sel_t   exp_dest0_sel;
  reg_sel_t   exp_dest1_sel;

  // Register file shadow and the instruction sitting in stage 1
  word_t       shadow_regs [8];
  logic        pend_valid;
  instr_win_t  pend_win;
  logic        pend_op16;
  logic        pend_ad16;
  logic [31:0] lfsr_state;
  int          cycle_count = 0;

  x86_decode_top i_dut (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic stop_with_failure(string reason);
    $display("%s", reason);
    $display("TEST FAILED");
    $fatal(1, "run stopped at %0t", $time);
  endtask

  task automatic report_mismatch(string name, logic [31:0] got, logic [31:0] expected);
    stop_with_failure($sformatf("Fail %s: got %h, expected %h", name, got, expected));
  endtask

  // Hang guard
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      stop_with_failure("simulation ran past the cycle limit without finishing");
    end
  end

  function automatic logic [31:0] lfsr_step(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] random_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  // Window with opcode and byte 1 fixed and random bytes 2..8
  function automatic instr_win_t make_win(logic [7:0] op, logic [7:0] modrm);
    logic [31:0] hi;
    logic [31:0] lo;
    hi = random_bits(32);
    lo = random_bits(24);
    return {hi, lo[23:0], modrm, op};
  endfunction

  // n bytes starting at byte pos, little endian, zero-extended
  function automatic logic [31:0] window_bytes(instr_win_t w, int pos, int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v[8*i +: 8] = w[8*(pos+i) +: 8];
    end
    return v;
  endfunction

  // AL..BL for 0-3, AH..BH for 4-7 when narrow
  function automatic word_t reg_value(reg_sel_t sel, logic narrow);
    word_t base;
    base = shadow_regs[sel[1:0]];
    if (!narrow) begin
      return shadow_regs[sel];
    end
    if (sel[2]) begin
      return {24'd0, base[15:8]};
    end
    return {24'd0, base[7:0]};
  endfunction

  // Reference decode of one window against the shadow registers
  task automatic predict(instr_win_t w, logic op16, logic ad16);
    logic [7:0]  op;
    logic [1:0]  md;
    logic [2:0]  rg;
    logic [2:0]  rm;
    opnd_form_t  form;
    logic        narrow;
    logic        imm8;
    logic        no_dest0;
    logic        str_mem;
    logic        swap_dest;
    logic        load_dest;
    logic        rm_first;
    logic        reg_first;
    logic        modrm_on;
    logic        imm_on;
    logic        reg0;
    logic        reg1;
    logic        mem0;
    reg_sel_t    sel0;
    reg_sel_t    sel1;
    int          pos;
    int          disp_n;
    int          imm_n;
    logic [31:0] raw;
    op        = w[7:0];
    md        = w[15:14];
    rg        = w[13:11];
    rm        = w[10:8];
    form      = FORM_NONE;
    narrow    = 1'b0;
    imm8      = 1'b0;
    no_dest0  = 1'b0;
    str_mem   = 1'b0;
    swap_dest = 1'b0;
    load_dest = 1'b0;
    // Opcode subset without ADC and SBB
    if (op <= 8'h3D && op[2:0] <= 3'd5 && op[5:3] != 3'd2 && op[5:3] != 3'd3) begin
      narrow   = !op[0];
      no_dest0 = op[5:3] == 3'd7;
      if (op[2:1] == 2'b00) begin
        form = FORM_RM_REG;
      end else if (op[2:1] == 2'b01) begin
        form = FORM_REG_RM;
      end else begin
        form = FORM_EAX_IMM;
        imm8 = !op[0];
      end
    end else if (op[7:4] == 4'h4) begin
      form = FORM_REG;
    end else if (op == 8'h69 || op == 8'h6B) begin
      form = FORM_REG_RM_IMM;
      imm8 = op == 8'h6B;
    end else if ((op == 8'h80 || op == 8'h81 || op == 8'h83) && rg != 3'd2 && rg != 3'd3) begin
      form     = FORM_RM_IMM;
      narrow   = op == 8'h80;
      imm8     = op != 8'h81;
      no_dest0 = rg == 3'd7;
    end else if (op[7:2] == 6'b100010) begin
      form      = op[1] ? FORM_REG_RM : FORM_RM_REG;
      narrow    = !op[0];
      load_dest = op[1];
    end else if (op[7:3] == 5'b10010) begin
      form      = FORM_EAX_REG;
      swap_dest = 1'b1;
    end else if (op[7:3] == 5'b10111) begin
      form = FORM_REG_IMM;
    end else if (op >= 8'hA4 && op <= 8'hAF && op != 8'hA8 && op != 8'hA9) begin
      // STOS has no memory source operand
      str_mem  = op != 8'hAA && op != 8'hAB;
      no_dest0 = op == 8'hA6 || op == 8'hA7;
    end

    rm_first  = form == FORM_RM || form == FORM_RM_IMM || form == FORM_RM_REG;
    reg_first = form == FORM_REG_RM || form == FORM_REG_RM_IMM;
    modrm_on  = rm_first || reg_first;
    imm_on    = form == FORM_REG_IMM || form == FORM_EAX_IMM || form == FORM_RM_IMM ||
                form == FORM_REG_RM_IMM;
    exp_has_sib = modrm_on && !ad16 && md != 2'b11 && rm == 3'b100;

    disp_n = 0;
    if (modrm_on && md == 2'b01) begin
      disp_n = 1;
    end else if (modrm_on && md == 2'b10) begin
      disp_n = ad16 ? 2 : 4;
    end else if (modrm_on && md == 2'b00 && !ad16 && rm == 3'b101) begin
      disp_n = 4;
    end else if (modrm_on && md == 2'b00 && ad16 && rm == 3'b110) begin
      disp_n = 2;
    end
    imm_n = !imm_on ? 0 : imm8 ? 1 : op16 ? 2 : 4;

    // Opcode, ModR/M, SIB, displacement, immediate
    pos = 1 + (modrm_on ? 1 : 0) + (exp_has_sib ? 1 : 0);
    raw = window_bytes(w, pos, disp_n);
    case (disp_n)
      1:       exp_disp = {{24{raw[7]}}, raw[7:0]};
      2:       exp_disp = {{16{raw[15]}}, raw[15:0]};
      default: exp_disp = raw;
    endcase
    exp_disp_1byte = disp_n == 1;
    pos = pos + disp_n;
    raw = window_bytes(w, pos, imm_n);
    // imm16 stays zero-extended
    exp_opnd2 = (imm_n == 1) ? {{24{raw[7]}}, raw[7:0]} : raw;
    exp_len   = instr_len_t'(pos + imm_n);

    reg0 = 1'b1;
    sel0 = REG_EAX;
    if (form == FORM_REG || form == FORM_REG_IMM) begin
      sel0 = op[2:0];
    end else if (rm_first && md == 2'b11) begin
      sel0 = rm;
    end else if (reg_first) begin
      sel0 = rg;
    end else if (form != FORM_EAX_IMM && form != FORM_EAX_REG) begin
      reg0 = 1'b0;
    end
    reg1 = 1'b1;
    sel1 = REG_EAX;
    if (form == FORM_RM_REG) begin
      sel1 = rg;
    end else if (reg_first && md == 2'b11) begin
      sel1 = rm;
    end else if (form == FORM_EAX_REG) begin
      sel1 = op[2:0];
    end else begin
      reg1 = 1'b0;
    end
    exp_opnd0 = reg0 ? reg_value(sel0, narrow) : '0;
    exp_opnd1 = reg1 ? reg_value(sel1, narrow) : '0;

    mem0 = (rm_first && md != 2'b11) || str_mem;
    exp_dest0_kind = no_dest0 ? DEST_NONE : mem0 ? DEST_MEM : reg0 ? DEST_REG : DEST_NONE;
    exp_dest0_sel  = (exp_dest0_kind == DEST_REG) ? sel0 : '0;
    exp_dest1_kind = (swap_dest || load_dest) ? DEST_REG : DEST_NONE;
    exp_dest1_sel  = swap_dest ? sel1 : load_dest ? sel0 : '0;
  endtask

  // One clock of stimulus driven 5 ns after the edge
  task automatic step_cycle(logic valid, instr_win_t w, logic op16, logic ad16,
                            logic we, reg_sel_t sel, word_t data);
    @(posedge clk);
    #5;
    // This cycle's write is already visible to the result leaving now
    if (we) begin
      shadow_regs[sel] = data;
    end
    exp_valid = pend_valid;
    if (pend_valid) begin
      predict(pend_win, pend_op16, pend_ad16);
    end
    instr_valid          = valid;
    instr                = w;
    prefix_operand_16bit = op16;
    prefix_address_16bit = ad16;
    wr_en                = we;
    wr_sel               = sel;
    wr_data              = data;
    pend_valid = valid;
    pend_win   = w;
    pend_op16  = op16;
    pend_ad16  = ad16;
  endtask

  task automatic send(instr_win_t w, logic op16, logic ad16);
    step_cycle(1'b1, w, op16, ad16, 1'b0, REG_EAX, '0);
  endtask

  task automatic idle_cycle();
    step_cycle(1'b0, '0, 1'b0, 1'b0, 1'b0, REG_EAX, '0);
  endtask

  task automatic write_reg(reg_sel_t sel, word_t data);
    step_cycle(1'b0, '0, 1'b0, 1'b0, 1'b1, sel, data);
  endtask

  // Result checks, sampled at the edge that ends the out_valid cycle
  a_valid: assert property (@(posedge clk) disable iff (rst) out_valid == exp_valid)
    else report_mismatch("out_valid", 32'($sampled(out_valid)), 32'($sampled(exp_valid)));
  a_opnd0: assert property (@(posedge clk) disable iff (rst) !out_valid || opnd0 == exp_opnd0)
    else report_mismatch("opnd0", $sampled(opnd0), $sampled(exp_opnd0));
  a_opnd1: assert property (@(posedge clk) disable iff (rst) !out_valid || opnd1 == exp_opnd1)
    else report_mismatch("opnd1", $sampled(opnd1), $sampled(exp_opnd1));
  a_opnd2: assert property (@(posedge clk) disable iff (rst) !out_valid || opnd2 == exp_opnd2)
    else report_mismatch("opnd2", $sampled(opnd2), $sampled(exp_opnd2));
  a_disp: assert property (@(posedge clk) disable iff (rst) !out_valid || disp == exp_disp)
    else report_mismatch("disp", $sampled(disp), $sampled(exp_disp));
  a_disp_1byte: assert property (@(posedge clk) disable iff (rst)
                                 !out_valid || disp_1byte == exp_disp_1byte)
    else report_mismatch("disp_1byte", 32'($sampled(disp_1byte)),
                         32'($sampled(exp_disp_1byte)));
  a_has_sib: assert property (@(posedge clk) disable iff (rst)
                              !out_valid || has_sib == exp_has_sib)
    else report_mismatch("has_sib", 32'($sampled(has_sib)), 32'($sampled(exp_has_sib)));
  a_len: assert property (@(posedge clk) disable iff (rst) !out_valid || instr_len == exp_len)
    else report_mismatch("instr_len", 32'($sampled(instr_len)), 32'($sampled(exp_len)));
  a_dest0_kind: assert property (@(posedge clk) disable iff (rst)
                                 !out_valid || dest0_kind == exp_dest0_kind)
    else report_mismatch("dest0_kind", 32'($sampled(dest0_kind)),
                         32'($sampled(exp_dest0_kind)));
  a_dest1_kind: assert property (@(posedge clk) disable iff (rst)
                                 !out_valid || dest1_kind == exp_dest1_kind)
    else report_mismatch("dest1_kind", 32'($sampled(dest1_kind)),
                         32'($sampled(exp_dest1_kind)));
  a_dest0_sel: assert property (@(posedge clk) disable iff (rst)
                                !out_valid || dest0_sel == exp_dest0_sel)
    else report_mismatch("dest0_sel", 32'($sampled(dest0_sel)), 32'($sampled(exp_dest0_sel)));
  a_dest1_sel: assert property (@(posedge clk) disable iff (rst)
                                !out_valid || dest1_sel == exp_dest1_sel)
    else report_mismatch("dest1_sel", 32'($sampled(dest1_sel)), 32'($sampled(exp_dest1_sel)));

  initial begin
    instr_win_t  w;
    logic [31:0] r;
    logic [31:0] s;
    rst                  = 1'b1;
    instr_valid          = 1'b0;
    instr                = '0;
    prefix_operand_16bit = 1'b0;
    prefix_address_16bit = 1'b0;
    wr_en                = 1'b0;
    wr_sel               = REG_EAX;
    wr_data              = '0;
    exp_valid            = 1'b0;
    pend_valid           = 1'b0;
    pend_win             = '0;
    pend_op16            = 1'b0;
    pend_ad16            = 1'b0;
    lfsr_state           = LFSR_SEED;
    for (int i = 0; i < 8; i++) begin
      shadow_regs[i] = '0;
    end
    repeat (10) @(posedge clk);
    #5;
    rst = 1'b0;

    // Idle after reset, then random register contents
    idle_cycle();
    idle_cycle();
    for (int i = 0; i < 8; i++) begin
      write_reg(reg_sel_t'(i), random_bits(32));
    end

    // Register-register forms including CMP and XCHG
    send(make_win(8'h01, 8'hC8), 1'b0, 1'b0);
    send(make_win(8'h2B, 8'hD3), 1'b0, 1'b0);
    idle_cycle();
    send(make_win(8'h39, 8'hF7), 1'b0, 1'b0);
    send(make_win(8'h31, 8'hE5), 1'b0, 1'b0);
    send(make_win(8'h23, 8'hC4), 1'b0, 1'b0);
    send(make_win(8'h0B, 8'hCA), 1'b0, 1'b0);
    send(make_win(8'h89, 8'hC6), 1'b0, 1'b0);
    send(make_win(8'h8B, 8'hF9), 1'b0, 1'b0);
    send(make_win(8'h93, 8'h00), 1'b0, 1'b0);
    send(make_win(8'h41, 8'h00), 1'b0, 1'b0);
    send(make_win(8'h4E, 8'h00), 1'b0, 1'b0);

    // Byte registers, low and high halves
    send(make_win(8'h00, 8'hE3), 1'b0, 1'b0);
    send(make_win(8'h8A, 8'hC7), 1'b0, 1'b0);
    send(make_win(8'h30, 8'hCE), 1'b0, 1'b0);
    send(make_win(8'h3A, 8'hEC), 1'b0, 1'b0);
    send(make_win(8'h04, 8'h7F), 1'b0, 1'b0);

    // Immediate forms with imm32, negative imm8 and imm16 under the operand prefix
    send(make_win(8'hBA, 8'h5A), 1'b0, 1'b0);
    w = make_win(8'h83, 8'hC1);
    w[23:16] = 8'hF3;
    send(w, 1'b0, 1'b0);
    w = make_win(8'h6B, 8'hC2);
    w[23:16] = 8'h9C;
    send(w, 1'b0, 1'b0);
    w = make_win(8'h05, 8'hEF);
    w[23:16] = 8'hBE;
    send(w, 1'b1, 1'b0);
    send(make_win(8'h80, 8'hF8), 1'b0, 1'b0);
    send(make_win(8'h81, 8'hE6), 1'b0, 1'b0);
    send(make_win(8'h69, 8'hD9), 1'b0, 1'b0);
    send(make_win(8'h81, 8'hC7), 1'b1, 1'b0);

    // Memory operands
    w = make_win(8'h01, 8'h44);
    w[23:16] = 8'h88;
    w[31:24] = 8'hF0;
    send(w, 1'b0, 1'b0);
    send(make_win(8'h8B, 8'h05), 1'b0, 1'b0);
    // rm 100 would take a SIB byte under 32-bit addressing
    send(make_win(8'h89, 8'h8C), 1'b0, 1'b1);
    w = make_win(8'h80, 8'h3C);
    w[23:16] = 8'h24;
    send(w, 1'b0, 1'b0);
    send(make_win(8'h69, 8'h45), 1'b0, 1'b0);
    send(make_win(8'h81, 8'h06), 1'b0, 1'b1);

    // String ops, then opcodes outside the subset
    send(make_win(8'hA5, 8'h00), 1'b0, 1'b0);
    send(make_win(8'hA7, 8'h00), 1'b0, 1'b0);
    send(make_win(8'hAB, 8'h00), 1'b0, 1'b0);
    send(make_win(8'hAD, 8'h00), 1'b0, 1'b0);
    send(make_win(8'hAE, 8'h00), 1'b0, 1'b0);
    send(make_win(8'hF4, 8'h00), 1'b0, 1'b0);
    send(make_win(8'h11, 8'hC8), 1'b0, 1'b0);
    idle_cycle();

    // Back-to-back writes landing in the result cycle
    send(make_win(8'h01, 8'hC8), 1'b0, 1'b0);
    step_cycle(1'b1, make_win(8'h29, 8'hD1), 1'b0, 1'b0, 1'b1, REG_ECX, random_bits(32));
    step_cycle(1'b1, make_win(8'h8B, 8'hD1), 1'b0, 1'b0, 1'b1, REG_EDX, random_bits(32));
    step_cycle(1'b0, '0, 1'b0, 1'b0, 1'b1, REG_ECX, random_bits(32));

    // Random reg-reg stream with a write every cycle
    for (int i = 0; i < 16; i++) begin
      r = random_bits(6);
      s = random_bits(3);
      w = make_win(i[0] ? 8'h03 : 8'h02, {2'b11, r[5:0]});
      step_cycle(1'b1, w, 1'b0, 1'b0, 1'b1, s[2:0], random_bits(32));
    end

    idle_cycle();
    idle_cycle();
    @(posedge clk);
    #1;
    $display("TEST OK");
    $finish;
  end

endmodule

`default_nettype wire

// ==== x86_decode_top.f ====
rtl/x86_decode_pkg.sv
rtl/gpr_file.sv
rtl/opcode_classify.sv
rtl/decode_opnds.sv
rtl/x86_decode_top.sv
sim/tb_x86_decode.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it, then judge the log
cd "$(dirname "$0")" &&
rm -f sim.log &&
verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_x86_decode \
  -f x86_decode_top.f -o tb_x86_decode &&
./obj_dir/tb_x86_decode > sim.log 2>&1
cat sim.log 2>/dev/null
! grep -q "TEST FAILED" sim.log && grep -q "TEST OK" sim.log || exit 1
